// ==== common/vslide_config.svh ====
// Package widths are derived from these sizes; lanes and rows must stay powers of two
`ifndef VSLIDE_CONFIG_SVH
`define VSLIDE_CONFIG_SVH

// Lanes, one element of each row per lane
`define VSLIDE_NR_LANES 4

// Architectural vector registers
`define VSLIDE_NR_REGS 8

// Rows per register, VLMAX is lanes times rows
`define VSLIDE_ROWS 4

// Instructions held by the slide unit
`define VSLIDE_INSN_DEPTH 2

// Pending writes per lane
`define VSLIDE_RESULT_DEPTH 2

`endif

// ==== common/vslide_pkg.sv ====
// Elements are fixed at 32 bits and vlen_t must be able to hold VLMAX itself
`include "vslide_config.svh"

package vslide_pkg;

  // Elements in one full register
  localparam int unsigned VLMAX = `VSLIDE_NR_LANES * `VSLIDE_ROWS;
  // Distinct instruction ids
  localparam int unsigned NrVInsn = 4;

  typedef logic [31:0] elem_t;
  typedef logic [$clog2(`VSLIDE_NR_REGS)-1:0] vreg_t;
  // Register in the upper bits, row in the lower bits
  typedef logic [$clog2(`VSLIDE_NR_REGS * `VSLIDE_ROWS)-1:0] row_addr_t;
  typedef logic [$clog2(VLMAX + 1)-1:0] vlen_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_dir_e;

  // One slide instruction as the host sends it
  typedef struct packed {
    vid_t       id;
    slide_dir_e dir;
    vreg_t      vs2;
    vreg_t      vd;
    vlen_t      offset;
    vlen_t      vl;
  } vinsn_t;

  // One pending VRF write of a lane
  typedef struct packed {
    row_addr_t addr;
    elem_t     data;
  } result_t;

endpackage

// ==== sldu/sldu_insn_queue.sv ====
// Issue and commit follow accept order; an id may not be pushed again before its commit
`timescale 1ns/1ps
`include "vslide_config.svh"

module sldu_insn_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Accept side
  input  logic               push_i,
  input  vslide_pkg::vinsn_t push_insn_i,
  output logic               full_o,
  // Issue side
  output vslide_pkg::vinsn_t issue_insn_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  // Commit side
  output vslide_pkg::vinsn_t commit_insn_o,
  output logic               commit_valid_o,
  input  logic               commit_done_i
);

  import vslide_pkg::*;

  localparam int unsigned Depth = `VSLIDE_INSN_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;

  vinsn_t insn_q [Depth];

  // One pointer per execution phase
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Waiting for issue, and waiting for commit (which includes the issuing ones)
  logic [PntW:0] issue_cnt_q, commit_cnt_q;
  // Ids between accept and commit
  logic [NrVInsn-1:0] running_d, running_q;

  function automatic logic [PntW-1:0] next_pnt(logic [PntW-1:0] pnt);
    return (pnt == PntW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full_o         = (commit_cnt_q == (PntW + 1)'(Depth));
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_valid_o = (commit_cnt_q != '0);
  assign issue_insn_o   = insn_q[issue_pnt_q];
  assign commit_insn_o  = insn_q[commit_pnt_q];

  // New entry lands at the accept pointer
  always_ff @(posedge clk_i) begin
    if (push_i) insn_q[accept_pnt_q] <= push_insn_i;
  end

  always_comb begin
    running_d = running_q;
    if (commit_done_i) running_d[commit_insn_o.id] = 1'b0;
    if (push_i) running_d[push_insn_i.id] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      running_q    <= '0;
    end else begin
      if (push_i) accept_pnt_q <= next_pnt(accept_pnt_q);
      if (issue_done_i) issue_pnt_q <= next_pnt(issue_pnt_q);
      if (commit_done_i) commit_pnt_q <= next_pnt(commit_pnt_q);
      issue_cnt_q  <= issue_cnt_q + (PntW + 1)'(push_i) - (PntW + 1)'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + (PntW + 1)'(push_i) - (PntW + 1)'(commit_done_i);
      running_q    <= running_d;
    end
  end

  // Ready from the top level must keep a full queue free of pushes
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into a full instruction queue");

  // Host rule, an id stays reserved until its done pulse
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !running_q[push_insn_i.id])
    else $error("id %0d pushed while still running", push_insn_i.id);

endmodule

// ==== sldu/sldu_result_queue.sv ====
// The head is offered on req_o until granted; the producer checks full_o before each push
`timescale 1ns/1ps
`include "vslide_config.svh"

module sldu_result_queue #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t push_data_i,
  output logic     full_o,
  output logic     empty_o,
  // VRF write side
  output logic     req_o,
  output payload_t data_o,
  input  logic     gnt_i
);

  localparam int unsigned Depth = `VSLIDE_RESULT_DEPTH;
  localparam int unsigned PntW  = (Depth > 1) ? $clog2(Depth) : 1;

  payload_t        mem_q [Depth];
  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;
  logic            pop;

  assign full_o  = (cnt_q == (PntW + 1)'(Depth));
  assign empty_o = (cnt_q == '0);
  assign req_o   = !empty_o;
  assign data_o  = mem_q[rd_pnt_q];
  // Head leaves on the granting edge
  assign pop     = req_o && gnt_i;

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_pnt_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) wr_pnt_q <= (wr_pnt_q == PntW'(Depth - 1)) ? '0 : wr_pnt_q + 1'b1;
      if (pop) rd_pnt_q <= (rd_pnt_q == PntW'(Depth - 1)) ? '0 : rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + (PntW + 1)'(push_i) - (PntW + 1)'(pop);
    end
  end

  // Slide unit stalls its row walk on full
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into a full result queue");

  // A withheld write keeps its address and data
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o && !gnt_i |=> req_o && $stable(data_o))
    else $error("result request dropped before its grant");

endmodule

// ==== sldu/sldu.sv ====
// 32-bit elements, no masking; slide-down zero-fills sources at or past vl
`timescale 1ns/1ps
`include "vslide_config.svh"

module sldu (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Instruction port
  input  logic                                         insn_valid_i,
  output logic                                         insn_ready_o,
  input  vslide_pkg::vid_t                             insn_id_i,
  input  vslide_pkg::slide_dir_e                       insn_dir_i,
  input  vslide_pkg::vreg_t                            insn_vs2_i,
  input  vslide_pkg::vreg_t                            insn_vd_i,
  input  vslide_pkg::vlen_t                            insn_offset_i,
  input  vslide_pkg::vlen_t                            insn_vl_i,
  output logic                                         done_o,
  output vslide_pkg::vid_t                             done_id_o,
  output logic                                         busy_o,
  // Row reads
  output logic                                         rd_req_o,
  output vslide_pkg::row_addr_t                        rd_addr_o,
  input  logic                                         rd_gnt_i,
  input  vslide_pkg::elem_t     [`VSLIDE_NR_LANES-1:0] rd_data_i,
  // Lane writes
  output logic                  [`VSLIDE_NR_LANES-1:0] wr_req_o,
  output vslide_pkg::row_addr_t [`VSLIDE_NR_LANES-1:0] wr_addr_o,
  output vslide_pkg::elem_t     [`VSLIDE_NR_LANES-1:0] wr_data_o,
  input  logic                  [`VSLIDE_NR_LANES-1:0] wr_gnt_i
);

  import vslide_pkg::*;

  localparam int unsigned NrLanes = `VSLIDE_NR_LANES;
  localparam int unsigned NrRows  = `VSLIDE_ROWS;
  localparam int unsigned LaneW   = $clog2(NrLanes);
  localparam int unsigned RowW    = $clog2(NrRows);

  // Source row of the walk, may run past the register end
  typedef logic [RowW+1:0] step_t;

  vinsn_t  insn_push, issue_insn, commit_insn;
  logic    queue_full, issue_valid, issue_done, commit_valid, commit_done;
  logic    active_q, proc_q, row_valid_q, own, step_go, empty_insn;
  step_t   step_q, step_start, step_end;
  vlen_t   done_cnt_q, gnt_cnt;
  logic    done_q;
  vid_t    done_id_q;

  // Offset as whole rows plus a lane rotation
  logic [RowW:0]   off_rows;
  logic [LaneW-1:0] off_lanes;
  logic [RowW-1:0] last_row;

  elem_t   [NrLanes-1:0]   prev_q, cur_row;
  elem_t   [2*NrLanes-1:0] window;
  logic    [NrLanes-1:0]   lane_we, lane_full, lane_empty;
  result_t [NrLanes-1:0]   lane_res, lane_out;

  // Writes one instruction leaves in the VRF
  function automatic vlen_t nr_writes(vinsn_t insn);
    if (insn.dir == SLIDE_DOWN) return insn.vl;
    return (insn.offset < insn.vl) ? vlen_t'(insn.vl - insn.offset) : '0;
  endfunction

  assign insn_push = '{id: insn_id_i, dir: insn_dir_i, vs2: insn_vs2_i, vd: insn_vd_i,
                       offset: insn_offset_i, vl: insn_vl_i};
  assign insn_ready_o = !queue_full;
  assign busy_o       = commit_valid;
  assign done_o       = done_q;
  assign done_id_o    = done_id_q;

  sldu_insn_queue i_insn_queue (
    .clk_i,
    .rst_ni,
    .push_i        (insn_valid_i && !queue_full),
    .push_insn_i   (insn_push),
    .full_o        (queue_full),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .commit_insn_o (commit_insn),
    .commit_valid_o(commit_valid),
    .commit_done_i (commit_done)
  );

  assign off_rows   = (RowW + 1)'(issue_insn.offset / NrLanes);
  assign off_lanes  = LaneW'(issue_insn.offset % NrLanes);
  assign last_row   = RowW'((issue_insn.vl - 1'b1) / NrLanes);
  assign empty_insn = (nr_writes(issue_insn) == '0);
  // Slide-up pairs rows r-q-1 and r-q, slide-down pairs r+q and r+q+1 after a priming read
  assign step_start = (issue_insn.dir == SLIDE_UP) ? '0 : step_t'(off_rows);
  assign step_end   = (issue_insn.dir == SLIDE_UP) ? step_t'(last_row) - step_t'(off_rows)
                                                   : step_t'(last_row) + step_t'(off_rows) + 1'b1;

  assign rd_req_o  = active_q && !proc_q && (step_q < step_t'(NrRows));
  assign rd_addr_o = {issue_insn.vs2, step_q[RowW-1:0]};
  assign cur_row   = row_valid_q ? rd_data_i : '0;
  // Previous row in the low half, current row in the high half
  assign window    = {cur_row, prev_q};

  // Results of the next instruction wait until the current commit is over
  assign own     = commit_valid && (commit_insn.id == issue_insn.id);
  assign step_go = active_q && proc_q && !(|(lane_we & lane_full)) && (own || !(|lane_we));
  assign issue_done = (step_go && step_q == step_end) || (issue_valid && !active_q && empty_insn);

  always_comb begin
    int row;
    int elem;
    row = int'(step_q) + int'(off_rows);
    if (issue_insn.dir == SLIDE_DOWN) row = int'(step_q) - int'(off_rows) - 1;
    for (int l = 0; l < NrLanes; l++) begin
      elem = row * NrLanes + l;
      lane_res[l].addr = {issue_insn.vd, RowW'(row)};
      if (issue_insn.dir == SLIDE_UP) begin
        // Elements below the offset keep their old value
        lane_we[l] = elem >= int'(issue_insn.offset) && elem < int'(issue_insn.vl);
        lane_res[l].data = window[NrLanes + l - int'(off_lanes)];
      end else begin
        lane_we[l] = row >= 0 && elem < int'(issue_insn.vl);
        // Zero where the source index reaches vl
        lane_res[l].data = (elem + int'(issue_insn.offset) < int'(issue_insn.vl)) ?
                           window[l + int'(off_lanes)] : '0;
      end
    end
  end

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    sldu_result_queue #(
      .payload_t(result_t)
    ) i_result_queue (
      .clk_i,
      .rst_ni,
      .push_i     (step_go && lane_we[l]),
      .push_data_i(lane_res[l]),
      .full_o     (lane_full[l]),
      .empty_o    (lane_empty[l]),
      .req_o      (wr_req_o[l]),
      .data_o     (lane_out[l]),
      .gnt_i      (wr_gnt_i[l])
    );
    assign wr_addr_o[l] = lane_out[l].addr;
    assign wr_data_o[l] = lane_out[l].data;
  end

  // Granted lane writes this cycle
  always_comb begin
    gnt_cnt = '0;
    for (int l = 0; l < NrLanes; l++) gnt_cnt = gnt_cnt + vlen_t'(wr_gnt_i[l]);
  end

  // Commit once issue has moved on and every write has been granted
  assign commit_done = commit_valid && !(issue_valid && own) &&
                       (done_cnt_q + gnt_cnt == nr_writes(commit_insn));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      proc_q      <= 1'b0;
      row_valid_q <= 1'b0;
      step_q      <= '0;
      done_cnt_q  <= '0;
      done_q      <= 1'b0;
      done_id_q   <= '0;
    end else begin
      done_q     <= commit_done;
      done_id_q  <= commit_insn.id;
      done_cnt_q <= commit_done ? '0 : done_cnt_q + gnt_cnt;
      if (!active_q) begin
        if (issue_valid && !empty_insn) begin
          active_q <= 1'b1;
          proc_q   <= 1'b0;
          step_q   <= step_start;
        end
      end else if (!proc_q) begin
        // Rows past the register end read as zero without a VRF access
        if (rd_gnt_i || step_q >= step_t'(NrRows)) begin
          proc_q      <= 1'b1;
          row_valid_q <= rd_gnt_i;
        end
      end else if (step_go) begin
        proc_q <= 1'b0;
        if (step_q == step_end) active_q <= 1'b0;
        else step_q <= step_q + 1'b1;
      end
    end
  end

  // Row kept for offsets that straddle two rows
  always_ff @(posedge clk_i) begin
    if (step_go) prev_q <= cur_row;
  end

  // A row read keeps its address until the VRF grants it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_addr_o))
    else $error("row read dropped before its grant");

  // Done pulse finds every lane drained of that instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |-> &lane_empty)
    else $error("done reported with writes still queued");

endmodule

// ==== rtl/vrf.sv ====
// Any host request blocks both slide ports for that cycle; contents are undefined after reset
`timescale 1ns/1ps
`include "vslide_config.svh"

module vrf (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  // Host port
  input  logic                                         host_req_i,
  input  logic                                         host_we_i,
  input  vslide_pkg::row_addr_t                        host_addr_i,
  input  logic [$clog2(`VSLIDE_NR_LANES)-1:0]          host_lane_i,
  input  vslide_pkg::elem_t                            host_wdata_i,
  output logic                                         host_gnt_o,
  output vslide_pkg::elem_t                            host_rdata_o,
  // Row read port
  input  logic                                         rd_req_i,
  input  vslide_pkg::row_addr_t                        rd_addr_i,
  output logic                                         rd_gnt_o,
  output vslide_pkg::elem_t     [`VSLIDE_NR_LANES-1:0] rd_data_o,
  // Lane write ports
  input  logic                  [`VSLIDE_NR_LANES-1:0] wr_req_i,
  input  vslide_pkg::row_addr_t [`VSLIDE_NR_LANES-1:0] wr_addr_i,
  input  vslide_pkg::elem_t     [`VSLIDE_NR_LANES-1:0] wr_data_i,
  output logic                  [`VSLIDE_NR_LANES-1:0] wr_gnt_o
);

  import vslide_pkg::*;

  localparam int unsigned NrLanes = `VSLIDE_NR_LANES;
  localparam int unsigned LaneW   = $clog2(NrLanes);
  localparam int unsigned Words   = `VSLIDE_NR_REGS * `VSLIDE_ROWS;

  // One bank per lane
  elem_t               bank_q [NrLanes][Words];
  elem_t [NrLanes-1:0] rd_data_q;
  elem_t               host_rdata_q;

  assign host_gnt_o   = host_req_i;
  assign rd_gnt_o     = rd_req_i && !host_req_i;
  assign wr_gnt_o     = host_req_i ? '0 : wr_req_i;
  assign rd_data_o    = rd_data_q;
  assign host_rdata_o = host_rdata_q;

  always_ff @(posedge clk_i) begin
    for (int l = 0; l < NrLanes; l++) begin
      if (host_req_i && host_we_i && host_lane_i == LaneW'(l)) begin
        bank_q[l][host_addr_i] <= host_wdata_i;
      end else if (wr_gnt_o[l]) begin
        bank_q[l][wr_addr_i[l]] <= wr_data_i[l];
      end
    end
  end

  // Read data one cycle after the grant, held until the next one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_q    <= '0;
      host_rdata_q <= '0;
    end else begin
      if (rd_gnt_o) begin
        for (int l = 0; l < NrLanes; l++) rd_data_q[l] <= bank_q[l][rd_addr_i];
      end
      if (host_req_i && !host_we_i) host_rdata_q <= bank_q[host_lane_i][host_addr_i];
    end
  end

endmodule

// ==== rtl/vslide_top.sv ====
// The host should touch the VRF only while busy_o is low; its requests always win
`timescale 1ns/1ps
`include "vslide_config.svh"

module vslide_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Instruction port
  input  logic                                insn_valid_i,
  output logic                                insn_ready_o,
  input  vslide_pkg::vid_t                    insn_id_i,
  input  vslide_pkg::slide_dir_e              insn_dir_i,
  input  vslide_pkg::vreg_t                   insn_vs2_i,
  input  vslide_pkg::vreg_t                   insn_vd_i,
  input  vslide_pkg::vlen_t                   insn_offset_i,
  input  vslide_pkg::vlen_t                   insn_vl_i,
  // Completion
  output logic                                done_o,
  output vslide_pkg::vid_t                    done_id_o,
  output logic                                busy_o,
  // Host VRF port
  input  logic                                host_req_i,
  input  logic                                host_we_i,
  input  vslide_pkg::row_addr_t               host_addr_i,
  input  logic [$clog2(`VSLIDE_NR_LANES)-1:0] host_lane_i,
  input  vslide_pkg::elem_t                   host_wdata_i,
  output logic                                host_gnt_o,
  output vslide_pkg::elem_t                   host_rdata_o
);

  import vslide_pkg::*;

  localparam int unsigned NrLanes = `VSLIDE_NR_LANES;

  // Row reads
  logic                  rd_req, rd_gnt;
  row_addr_t             rd_addr;
  elem_t   [NrLanes-1:0] rd_data;
  // Lane writes
  logic      [NrLanes-1:0] wr_req, wr_gnt;
  row_addr_t [NrLanes-1:0] wr_addr;
  elem_t     [NrLanes-1:0] wr_data;

  sldu i_sldu (
    .clk_i,
    .rst_ni,
    .insn_valid_i,
    .insn_ready_o,
    .insn_id_i,
    .insn_dir_i,
    .insn_vs2_i,
    .insn_vd_i,
    .insn_offset_i,
    .insn_vl_i,
    .done_o,
    .done_id_o,
    .busy_o,
    .rd_req_o (rd_req),
    .rd_addr_o(rd_addr),
    .rd_gnt_i (rd_gnt),
    .rd_data_i(rd_data),
    .wr_req_o (wr_req),
    .wr_addr_o(wr_addr),
    .wr_data_o(wr_data),
    .wr_gnt_i (wr_gnt)
  );

  vrf i_vrf (
    .clk_i,
    .rst_ni,
    .host_req_i,
    .host_we_i,
    .host_addr_i,
    .host_lane_i,
    .host_wdata_i,
    .host_gnt_o,
    .host_rdata_o,
    .rd_req_i (rd_req),
    .rd_addr_i(rd_addr),
    .rd_gnt_o (rd_gnt),
    .rd_data_o(rd_data),
    .wr_req_i (wr_req),
    .wr_addr_i(wr_addr),
    .wr_data_i(wr_data),
    .wr_gnt_o (wr_gnt)
  );

endmodule

// ==== test/tb_vslide.sv ====
// Host VRF traffic runs only between instructions except in the contention run; ids reused after done
`timescale 1ns/1ps
`include "vslide_config.svh"

module tb_vslide;

  import vslide_pkg::*;

  localparam int unsigned Timeout = 1000;
  localparam int unsigned NrLanes = `VSLIDE_NR_LANES;
  localparam int unsigned NrRegs  = `VSLIDE_NR_REGS;
  localparam int unsigned NrRows  = `VSLIDE_ROWS;

  typedef logic [$clog2(NrLanes)-1:0] lane_t;

  // One stimulus row
  typedef struct {
    slide_dir_e dir;
    vreg_t      vs2;
    vreg_t      vd;
    vlen_t      offset;
    vlen_t      vl;
    vid_t       id;
  } insn_row_t;

  logic       clk;
  logic       rst_n;
  logic       insn_valid;
  logic       insn_ready;
  vid_t       insn_id;
  slide_dir_e insn_dir;
  vreg_t      insn_vs2;
  vreg_t      insn_vd;
  vlen_t      insn_offset;
  vlen_t      insn_vl;
  logic       done;
  vid_t       done_id;
  logic       busy;
  logic       host_req;
  logic       host_we;
  row_addr_t  host_addr;
  lane_t      host_lane;
  elem_t      host_wdata;
  logic       host_gnt;
  elem_t      host_rdata;

  // Reference copy of the register file
  elem_t       model [NrRegs][VLMAX];
  insn_row_t   insn_table [$];
  vid_t        done_ids [$];
  integer      seed;
  int unsigned error_cnt;
  int unsigned insn_cnt;

  vslide_top vslide_top_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .insn_valid_i (insn_valid),
    .insn_ready_o (insn_ready),
    .insn_id_i    (insn_id),
    .insn_dir_i   (insn_dir),
    .insn_vs2_i   (insn_vs2),
    .insn_vd_i    (insn_vd),
    .insn_offset_i(insn_offset),
    .insn_vl_i    (insn_vl),
    .done_o       (done),
    .done_id_o    (done_id),
    .busy_o       (busy),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_lane_i  (host_lane),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rdata_o (host_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Every done pulse is logged once per cycle it is high
  always @(negedge clk) begin
    if (rst_n && done) done_ids.push_back(done_id);
  end

  task automatic stop_on_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    $display("Instructions: %0d, done pulses: %0d, errors: %0d", insn_cnt, done_ids.size(),
             error_cnt + 1);
    $display("Test FAILED");
    $finish;
  endtask

  // Host always wins, so a request is granted in its own cycle
  task automatic verify_grant(input logic expected);
    if (host_gnt !== expected) begin
      error_cnt++;
      $display("Error: host_gnt_o got %h expected %h", host_gnt, expected);
    end
  endtask

  task automatic add_row(input slide_dir_e dir, input int vs2, input int vd, input int offset,
                         input int vl, input int id);
    insn_row_t row;
    row = '{dir, vreg_t'(vs2), vreg_t'(vd), vlen_t'(offset), vlen_t'(vl), vid_t'(id)};
    insn_table.push_back(row);
  endtask

  // Called and returns on a falling edge
  task automatic host_write(input int reg_idx, input int elem, input elem_t data);
    host_req   = 1'b1;
    host_we    = 1'b1;
    host_addr  = row_addr_t'(reg_idx * NrRows + elem / NrLanes);
    host_lane  = lane_t'(elem % NrLanes);
    host_wdata = data;
    @(posedge clk);
    verify_grant(1'b1);
    @(negedge clk);
    host_req   = 1'b0;
    host_we    = 1'b0;
  endtask

  // Data is registered on the rising edge after the grant
  task automatic host_read(input int reg_idx, input int elem, output elem_t data);
    host_req  = 1'b1;
    host_we   = 1'b0;
    host_addr = row_addr_t'(reg_idx * NrRows + elem / NrLanes);
    host_lane = lane_t'(elem % NrLanes);
    @(posedge clk);
    verify_grant(1'b1);
    @(negedge clk);
    data      = host_rdata;
    host_req  = 1'b0;
  endtask

  task automatic load_vrf();
    elem_t val;
    for (int r = 0; r < NrRegs; r++) begin
      for (int i = 0; i < VLMAX; i++) begin
        val = $random(seed);
        model[r][i] = val;
        host_write(r, i, val);
      end
    end
  endtask

  task automatic check_reg(input int reg_idx);
    elem_t got;
    for (int i = 0; i < VLMAX; i++) begin
      host_read(reg_idx, i, got);
      if (got !== model[reg_idx][i]) begin
        error_cnt++;
        $display("Error: host_rdata_o v%0d element %0d got %h expected %h", reg_idx, i, got,
                 model[reg_idx][i]);
      end
    end
  endtask

  // Slide rules applied to the reference copy
  task automatic apply_model(input insn_row_t e);
    elem_t src [VLMAX];
    for (int i = 0; i < VLMAX; i++) src[i] = model[e.vs2][i];
    for (int i = 0; i < VLMAX; i++) begin
      if (e.dir == SLIDE_UP) begin
        if (i >= int'(e.offset) && i < int'(e.vl)) model[e.vd][i] = src[i - int'(e.offset)];
      end else if (i < int'(e.vl)) begin
        // Sources at or past vl read as zero
        model[e.vd][i] = (i + int'(e.offset) < int'(e.vl)) ? src[i + int'(e.offset)] : '0;
      end
    end
  endtask

  // Returns on the falling edge after the transfer, valid still high
  task automatic drive_insn(input insn_row_t e);
    int unsigned cyc;
    cyc         = 0;
    insn_valid  = 1'b1;
    insn_id     = e.id;
    insn_dir    = e.dir;
    insn_vs2    = e.vs2;
    insn_vd     = e.vd;
    insn_offset = e.offset;
    insn_vl     = e.vl;
    while (!insn_ready) begin
      @(negedge clk);
      cyc++;
      if (cyc > Timeout) stop_on_timeout("insn_ready_o");
    end
    @(negedge clk);
    insn_cnt++;
  endtask

  task automatic wait_dones(input int unsigned count, input string what);
    int unsigned cyc;
    cyc = 0;
    while (done_ids.size() < count) begin
      @(negedge clk);
      cyc++;
      if (cyc > Timeout) stop_on_timeout(what);
    end
  endtask

  task automatic run_single(input insn_row_t e);
    drive_insn(e);
    insn_valid = 1'b0;
    if (busy !== 1'b1) begin
      error_cnt++;
      $display("Error: busy_o got %h expected %h", busy, 1'b1);
    end
    wait_dones(insn_cnt, "done_o of a single slide");
    if (done_ids[insn_cnt-1] !== e.id) begin
      error_cnt++;
      $display("Error: done_id_o got %h expected %h", done_ids[insn_cnt-1], e.id);
    end
    if (busy !== 1'b0) begin
      error_cnt++;
      $display("Error: busy_o got %h expected %h", busy, 1'b0);
    end
    apply_model(e);
    check_reg(e.vd);
    // A stretched pulse would have been logged twice by now
    if (done_ids.size() != insn_cnt) begin
      error_cnt++;
      $display("Error: done_o pulse count got %h expected %h", done_ids.size(), insn_cnt);
    end
  endtask

  task automatic back_to_back();
    insn_row_t first;
    insn_row_t second;
    int unsigned base;
    // Disjoint registers, so the overlap cannot form a hazard
    first  = '{SLIDE_UP, vreg_t'(0), vreg_t'(1), vlen_t'(2), vlen_t'(16), vid_t'(0)};
    second = '{SLIDE_DOWN, vreg_t'(2), vreg_t'(3), vlen_t'(6), vlen_t'(14), vid_t'(1)};
    base   = insn_cnt;
    drive_insn(first);
    if (insn_ready !== 1'b1) begin
      error_cnt++;
      $display("Error: insn_ready_o got %h expected %h", insn_ready, 1'b1);
    end
    drive_insn(second);
    insn_valid = 1'b0;
    if (insn_ready !== 1'b0) begin
      error_cnt++;
      $display("Error: insn_ready_o got %h expected %h", insn_ready, 1'b0);
    end
    wait_dones(base + 2, "done_o of two queued slides");
    if (done_ids[base] !== first.id || done_ids[base+1] !== second.id) begin
      error_cnt++;
      $display("Error: done_id_o order got %h %h expected %h %h", done_ids[base],
               done_ids[base+1], first.id, second.id);
    end
    apply_model(first);
    apply_model(second);
    check_reg(1);
    check_reg(3);
    if (done_ids.size() != insn_cnt) begin
      error_cnt++;
      $display("Error: done_o pulse count got %h expected %h", done_ids.size(), insn_cnt);
    end
  endtask

  // Host writes to v7 steal VRF cycles while a slide-up runs on v4 and v5
  task automatic contention_run();
    insn_row_t   e;
    int unsigned cyc;
    int unsigned k;
    int          elem;
    elem_t       val;
    e   = '{SLIDE_UP, vreg_t'(4), vreg_t'(5), vlen_t'(7), vlen_t'(13), vid_t'(2)};
    cyc = 0;
    k   = 0;
    drive_insn(e);
    insn_valid = 1'b0;
    while (done_ids.size() < insn_cnt) begin
      if (($random(seed) & 3) != 0) begin
        val  = $random(seed);
        elem = int'(k % NrRows) * NrLanes + int'((k / NrRows) % NrLanes);
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = row_addr_t'(7 * NrRows + elem / NrLanes);
        host_lane  = lane_t'(elem % NrLanes);
        host_wdata = val;
        model[7][elem] = val;
        k++;
      end else begin
        host_req = 1'b0;
      end
      @(negedge clk);
      cyc++;
      if (cyc > Timeout) stop_on_timeout("done_o under host traffic");
    end
    host_req = 1'b0;
    host_we  = 1'b0;
    if (done_ids[insn_cnt-1] !== e.id) begin
      error_cnt++;
      $display("Error: done_id_o got %h expected %h", done_ids[insn_cnt-1], e.id);
    end
    apply_model(e);
    check_reg(5);
    check_reg(7);
  endtask

  initial begin
    rst_n       = 1'b0;
    insn_valid  = 1'b0;
    insn_id     = '0;
    insn_dir    = SLIDE_UP;
    insn_vs2    = '0;
    insn_vd     = '0;
    insn_offset = '0;
    insn_vl     = '0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_lane   = '0;
    host_wdata  = '0;
    seed        = 32'hccad5c72;
    error_cnt   = 0;
    insn_cnt    = 0;
    // Slide-up rows, then the same offsets as slide-down
    add_row(SLIDE_UP, 0, 1, 0, 16, 0);
    add_row(SLIDE_UP, 1, 2, 1, 16, 1);
    add_row(SLIDE_UP, 2, 3, 3, 16, 2);
    add_row(SLIDE_UP, 3, 4, 4, 16, 3);
    add_row(SLIDE_UP, 4, 5, 5, 16, 0);
    add_row(SLIDE_UP, 5, 6, 0, 9, 1);
    add_row(SLIDE_UP, 6, 7, 1, 9, 2);
    add_row(SLIDE_UP, 7, 0, 3, 9, 3);
    add_row(SLIDE_UP, 0, 2, 4, 9, 0);
    add_row(SLIDE_UP, 1, 3, 5, 9, 1);
    add_row(SLIDE_DOWN, 2, 4, 0, 16, 2);
    add_row(SLIDE_DOWN, 3, 5, 1, 16, 3);
    add_row(SLIDE_DOWN, 4, 6, 3, 16, 0);
    add_row(SLIDE_DOWN, 5, 7, 4, 16, 1);
    add_row(SLIDE_DOWN, 6, 0, 5, 16, 2);
    add_row(SLIDE_DOWN, 7, 1, 0, 9, 3);
    add_row(SLIDE_DOWN, 0, 3, 1, 9, 0);
    add_row(SLIDE_DOWN, 1, 4, 3, 9, 1);
    add_row(SLIDE_DOWN, 2, 5, 4, 9, 2);
    add_row(SLIDE_DOWN, 3, 6, 5, 9, 3);
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    // Idle state out of reset
    if (insn_ready !== 1'b1 || busy !== 1'b0 || done !== 1'b0) begin
      error_cnt++;
      $display("Error: insn_ready_o busy_o done_o got %h %h %h expected 1 0 0", insn_ready,
               busy, done);
    end
    // No request, no grant
    verify_grant(1'b0);
    load_vrf();
    for (int r = 0; r < NrRegs; r++) check_reg(r);
    foreach (insn_table[i]) run_single(insn_table[i]);
    back_to_back();
    contention_run();
    $display("Instructions: %0d, done pulses: %0d, errors: %0d", insn_cnt, done_ids.size(),
             error_cnt);
    if (error_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== vslide.f ====
+incdir+common
common/vslide_pkg.sv
sldu/sldu_insn_queue.sv
sldu/sldu_result_queue.sv
sldu/sldu.sv
rtl/vrf.sv
rtl/vslide_top.sv
test/tb_vslide.sv

// ==== Bender.yml ====
package:
  name: vslide

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/vslide_pkg.sv
      - sldu/sldu_insn_queue.sv
      - sldu/sldu_result_queue.sv
      - sldu/sldu.sv
      - rtl/vrf.sv
      - rtl/vslide_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_vslide.sv
